//--- dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// datapath width
`define XLEN 32

// architectural registers including x0
`define REG_NUM 32
`define REG_ADDR_LEN 5

// decoded opcode field
`define OPCODE_LEN 7

// tag width must cover ROB_SIZE exactly
`define ROB_SIZE 8
`define ROB_TAG_LEN 3

// reservation stations
// depth is also the starting credit count per class
`define RS_DEPTH 2
`define CREDIT_LEN 2

// int, mul, branch, load/store
`define FU_NUM 4

`endif

//--- dispatch_pkg.sv
`include "dispatch_consts.svh"

package dispatch_pkg;

    typedef logic [`XLEN-1:0] data_t;
    typedef logic [`REG_ADDR_LEN-1:0] reg_addr_t;
    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;
    typedef logic [`CREDIT_LEN-1:0] credit_t;

    // station class, also the bit index in rs_load
    typedef enum logic [1:0] {
        FU_INT = 2'd0,
        FU_MUL = 2'd1,
        FU_BR  = 2'd2,
        FU_MEM = 2'd3
    } fu_class_t;

    // where a source operand comes from
    typedef enum logic [1:0] {
        SRC_REG  = 2'b00,
        SRC_WAIT = 2'b01,
        SRC_ROB  = 2'b11
    } src_stat_t;

    typedef struct packed {
        logic [`OPCODE_LEN-1:0] opcode;
        fu_class_t              fu_class;
        reg_addr_t              rd;
        reg_addr_t              rs1;
        reg_addr_t              rs2;
        logic                   has_rd;
    } decoded_inst_t;

    typedef struct packed {
        logic [`OPCODE_LEN-1:0] opcode;
        rob_tag_t               dest_tag;
        logic                   src1_ready;
        rob_tag_t               src1_tag;
        data_t                  src1_value;
        logic                   src2_ready;
        rob_tag_t               src2_tag;
        data_t                  src2_value;
    } rs_entry_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        rob_tag_t  tag;
        reg_addr_t rd;
        logic      has_rd;
        data_t     value;
    } commit_t;

    typedef struct packed {
        logic     busy;
        rob_tag_t tag;
    } map_lookup_t;

endpackage

//--- arch_regfile.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module arch_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  dispatch_pkg::reg_addr_t read_addr1,
    input  dispatch_pkg::reg_addr_t read_addr2,
    input  dispatch_pkg::commit_t   commit,
    output dispatch_pkg::data_t     reg_value1,
    output dispatch_pkg::data_t     reg_value2
);
    import dispatch_pkg::*;

    data_t regs [`REG_NUM];
    logic  write_en;

    // x0 is never written
    assign write_en = commit.valid && commit.has_rd && (commit.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[commit.rd] <= commit.value;
        end
    end

    // asynchronous reads with x0 forced to zero
    assign reg_value1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
    assign reg_value2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

endmodule

//--- map_table.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module map_table (
    input  logic                      clk,
    input  logic                      reset,
    input  dispatch_pkg::reg_addr_t   rs1,
    input  dispatch_pkg::reg_addr_t   rs2,
    input  logic                      map_write,
    input  dispatch_pkg::reg_addr_t   write_rd,
    input  dispatch_pkg::rob_tag_t    write_tag,
    input  dispatch_pkg::commit_t     commit,
    output dispatch_pkg::map_lookup_t map_src1,
    output dispatch_pkg::map_lookup_t map_src2
);
    import dispatch_pkg::*;

    logic [`REG_NUM-1:0] busy;
    rob_tag_t            tag_q [`REG_NUM];
    logic                commit_clear;

    // only clear if no younger writer has renamed rd since
    assign commit_clear = commit.valid && commit.has_rd && busy[commit.rd]
                          && (tag_q[commit.rd] == commit.tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (commit_clear) begin
                busy[commit.rd] <= 1'b0;
            end
            // dispatch of the same rd overrides the clear
            if (map_write && (write_rd != '0)) begin
                busy[write_rd] <= 1'b1;
            end
        end
    end

    // tag of the latest writer of each register
    always_ff @(posedge clk) begin
        if (map_write) begin
            tag_q[write_rd] <= write_tag;
        end
    end

    always_comb begin
        map_src1.busy = busy[rs1] && (rs1 != '0);
        map_src1.tag  = tag_q[rs1];
        map_src2.busy = busy[rs2] && (rs2 != '0);
        map_src2.tag  = tag_q[rs2];
    end

endmodule

//--- rob.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module rob (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rob_alloc,
    input  dispatch_pkg::reg_addr_t alloc_rd,
    input  logic                    alloc_has_rd,
    input  dispatch_pkg::cdb_t      cdb,
    input  dispatch_pkg::rob_tag_t  lookup_tag1,
    input  dispatch_pkg::rob_tag_t  lookup_tag2,
    output dispatch_pkg::rob_tag_t  rob_tail_tag,
    output logic                    rob_full,
    output logic                    rob_done1,
    output logic                    rob_done2,
    output dispatch_pkg::data_t     rob_value1,
    output dispatch_pkg::data_t     rob_value2,
    output dispatch_pkg::commit_t   commit
);
    import dispatch_pkg::*;

    rob_tag_t                head;
    rob_tag_t                tail;
    logic [`ROB_TAG_LEN:0]   count;
    logic [`ROB_SIZE-1:0]    done;
    logic                    retire;

    // entry payload
    reg_addr_t rd_q     [`ROB_SIZE];
    logic      has_rd_q [`ROB_SIZE];
    data_t     value_q  [`ROB_SIZE];

    assign rob_full     = (count == (`ROB_TAG_LEN+1)'(`ROB_SIZE));
    assign rob_tail_tag = tail;

    // head retires one cycle after its result lands
    assign retire = (count != '0) && done[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (rob_alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({rob_alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            rd_q[tail]     <= alloc_rd;
            has_rd_q[tail] <= alloc_has_rd;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
        end
    end

    // operand lookup for the dispatcher
    assign rob_done1  = done[lookup_tag1];
    assign rob_done2  = done[lookup_tag2];
    assign rob_value1 = value_q[lookup_tag1];
    assign rob_value2 = value_q[lookup_tag2];

    always_comb begin
        commit.valid  = retire;
        commit.tag    = head;
        commit.rd     = rd_q[head];
        commit.has_rd = has_rd_q[head];
        commit.value  = value_q[head];
    end

endmodule

//--- dispatcher.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatcher (
    input  logic                        clk,
    input  logic                        reset,
    input  dispatch_pkg::decoded_inst_t dec,
    input  logic                        dec_valid,
    input  logic [`FU_NUM-1:0]          rs_credit_return,
    input  dispatch_pkg::cdb_t          cdb,
    input  dispatch_pkg::map_lookup_t   map_src1,
    input  dispatch_pkg::map_lookup_t   map_src2,
    input  dispatch_pkg::rob_tag_t      rob_tail_tag,
    input  logic                        rob_full,
    input  logic                        rob_done1,
    input  logic                        rob_done2,
    input  dispatch_pkg::data_t         rob_value1,
    input  dispatch_pkg::data_t         rob_value2,
    input  dispatch_pkg::data_t         reg_value1,
    input  dispatch_pkg::data_t         reg_value2,
    output logic                        dispatch_stall,
    output dispatch_pkg::rs_entry_t     rs_entry,
    output logic [`FU_NUM-1:0]          rs_load,
    output logic                        rob_alloc,
    output logic                        map_write
);
    import dispatch_pkg::*;

    credit_t   credits [`FU_NUM];
    logic      has_credit;
    logic      accept;
    src_stat_t stat1;
    src_stat_t stat2;

    function automatic logic cdb_hit(map_lookup_t m, cdb_t bus);
        return bus.valid && (bus.tag == m.tag);
    endfunction

    // producer finished earlier, or is on the bus right now
    function automatic src_stat_t src_status(map_lookup_t m, logic done, cdb_t bus);
        if (!m.busy) begin
            return SRC_REG;
        end else if (done || cdb_hit(m, bus)) begin
            return SRC_ROB;
        end
        return SRC_WAIT;
    endfunction

    function automatic data_t src_value(src_stat_t stat, map_lookup_t m, data_t reg_val,
                                        data_t rob_val, cdb_t bus);
        case (stat)
            SRC_REG: return reg_val;
            SRC_ROB: return cdb_hit(m, bus) ? bus.value : rob_val;
            default: return '0;
        endcase
    endfunction

    assign stat1 = src_status(map_src1, rob_done1, cdb);
    assign stat2 = src_status(map_src2, rob_done2, cdb);

    always_comb begin
        rs_entry.opcode     = dec.opcode;
        rs_entry.dest_tag   = rob_tail_tag;
        rs_entry.src1_ready = (stat1 != SRC_WAIT);
        rs_entry.src1_tag   = (stat1 == SRC_REG) ? '0 : map_src1.tag;
        rs_entry.src1_value = src_value(stat1, map_src1, reg_value1, rob_value1, cdb);
        rs_entry.src2_ready = (stat2 != SRC_WAIT);
        rs_entry.src2_tag   = (stat2 == SRC_REG) ? '0 : map_src2.tag;
        rs_entry.src2_value = src_value(stat2, map_src2, reg_value2, rob_value2, cdb);
    end

    // stall on a full ROB or an empty credit pool for the target class
    assign has_credit     = (credits[dec.fu_class] != '0);
    assign dispatch_stall = dec_valid && (rob_full || !has_credit);
    assign accept         = dec_valid && !dispatch_stall;

    always_comb begin
        for (int i = 0; i < `FU_NUM; i++) begin
            rs_load[i] = accept && (dec.fu_class == fu_class_t'(i));
        end
    end

    assign rob_alloc = accept;
    assign map_write = accept && dec.has_rd && (dec.rd != '0);

    // one credit spent per load, one back per returned bit
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FU_NUM; i++) begin
                credits[i] <= credit_t'(`RS_DEPTH);
            end
        end else begin
            for (int i = 0; i < `FU_NUM; i++) begin
                case ({rs_load[i], rs_credit_return[i]})
                    2'b10:   credits[i] <= credits[i] - 1'b1;
                    2'b01:   credits[i] <= credits[i] + 1'b1;
                    default: credits[i] <= credits[i];
                endcase
            end
        end
    end

endmodule

//--- dispatch_top.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_top (
    input  logic                        clk,
    input  logic                        reset,
    input  dispatch_pkg::decoded_inst_t dec,
    input  logic                        dec_valid,
    input  logic [`FU_NUM-1:0]          rs_credit_return,
    input  dispatch_pkg::cdb_t          cdb,
    output logic                        dispatch_stall,
    output dispatch_pkg::rs_entry_t     rs_entry,
    output logic [`FU_NUM-1:0]          rs_load,
    output dispatch_pkg::commit_t       commit
);
    import dispatch_pkg::*;

    map_lookup_t map_src1;
    map_lookup_t map_src2;
    rob_tag_t    rob_tail_tag;
    logic        rob_full;
    logic        rob_done1;
    logic        rob_done2;
    data_t       rob_value1;
    data_t       rob_value2;
    data_t       reg_value1;
    data_t       reg_value2;
    logic        rob_alloc;
    logic        map_write;

    dispatcher u_dispatcher (
        .clk              (clk),
        .reset            (reset),
        .dec              (dec),
        .dec_valid        (dec_valid),
        .rs_credit_return (rs_credit_return),
        .cdb              (cdb),
        .map_src1         (map_src1),
        .map_src2         (map_src2),
        .rob_tail_tag     (rob_tail_tag),
        .rob_full         (rob_full),
        .rob_done1        (rob_done1),
        .rob_done2        (rob_done2),
        .rob_value1       (rob_value1),
        .rob_value2       (rob_value2),
        .reg_value1       (reg_value1),
        .reg_value2       (reg_value2),
        .dispatch_stall   (dispatch_stall),
        .rs_entry         (rs_entry),
        .rs_load          (rs_load),
        .rob_alloc        (rob_alloc),
        .map_write        (map_write)
    );

    map_table u_map_table (
        .clk       (clk),
        .reset     (reset),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .map_write (map_write),
        .write_rd  (dec.rd),
        .write_tag (rob_tail_tag),
        .commit    (commit),
        .map_src1  (map_src1),
        .map_src2  (map_src2)
    );

    // lookup by the tag the map table reports for each source
    rob u_rob (
        .clk          (clk),
        .reset        (reset),
        .rob_alloc    (rob_alloc),
        .alloc_rd     (dec.rd),
        .alloc_has_rd (dec.has_rd),
        .cdb          (cdb),
        .lookup_tag1  (map_src1.tag),
        .lookup_tag2  (map_src2.tag),
        .rob_tail_tag (rob_tail_tag),
        .rob_full     (rob_full),
        .rob_done1    (rob_done1),
        .rob_done2    (rob_done2),
        .rob_value1   (rob_value1),
        .rob_value2   (rob_value2),
        .commit       (commit)
    );

    arch_regfile u_arch_regfile (
        .clk        (clk),
        .reset      (reset),
        .read_addr1 (dec.rs1),
        .read_addr2 (dec.rs2),
        .commit     (commit),
        .reg_value1 (reg_value1),
        .reg_value2 (reg_value2)
    );

endmodule

//--- tb_dispatch.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module tb_dispatch;
    import dispatch_pkg::*;

    logic               clk;
    logic               reset;
    decoded_inst_t      dec;
    logic               dec_valid;
    logic [`FU_NUM-1:0] rs_credit_return;
    cdb_t               cdb;
    logic               dispatch_stall;
    rs_entry_t          rs_entry;
    logic [`FU_NUM-1:0] rs_load;
    commit_t            commit;

    logic [31:0] fields [16];
    commit_t     commit_q [$];
    // has_rd of each dispatched tag, checked at commit
    logic        has_rd_by_tag [`ROB_SIZE];
    int          errors;
    int          pass_count;
    int          fail_count;

    dispatch_top u_dispatch_top (
        .clk              (clk),
        .reset            (reset),
        .dec              (dec),
        .dec_valid        (dec_valid),
        .rs_credit_return (rs_credit_return),
        .cdb              (cdb),
        .dispatch_stall   (dispatch_stall),
        .rs_entry         (rs_entry),
        .rs_load          (rs_load),
        .commit           (commit)
    );

    always #50 clk = ~clk;

    // every retirement is queued for the C commands
    always @(negedge clk) begin
        if (!reset && commit.valid) begin
            commit_q.push_back(commit);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // bus and credit returns only last one cycle
    task automatic drive_idle();
        rs_credit_return <= '0;
        cdb              <= '0;
    endtask

    function automatic decoded_inst_t decode_fields();
        decoded_inst_t inst;
        inst.opcode   = 7'($urandom);
        inst.fu_class = fu_class_t'(fields[0][1:0]);
        inst.rd       = fields[1][4:0];
        inst.rs1      = fields[2][4:0];
        inst.rs2      = fields[3][4:0];
        inst.has_rd   = fields[4][0];
        return inst;
    endfunction

    task automatic dispatch_inst();
        decoded_inst_t inst;
        cdb_t          bus;
        int            n;
        inst      = decode_fields();
        bus.valid = fields[5][0];
        bus.tag   = fields[6][2:0];
        bus.value = fields[7];
        @(posedge clk);
        drive_idle();
        dec       <= inst;
        dec_valid <= 1'b1;
        cdb       <= bus;
        @(negedge clk);
        n = 0;
        while (dispatch_stall && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (dispatch_stall) begin
            $display("timeout: dispatch still stalled after 20 cycles at t=%0t", $time);
            errors++;
        end else begin
            has_rd_by_tag[fields[15][2:0]] = inst.has_rd;
            check_value("rs_load", fields[8], rs_load);
            check_value("opcode", inst.opcode, rs_entry.opcode);
            check_value("src1_ready", fields[9], rs_entry.src1_ready);
            check_value("src1_tag", fields[10], rs_entry.src1_tag);
            check_value("src1_value", fields[11], rs_entry.src1_value);
            check_value("src2_ready", fields[12], rs_entry.src2_ready);
            check_value("src2_tag", fields[13], rs_entry.src2_tag);
            check_value("src2_value", fields[14], rs_entry.src2_value);
            check_value("dest_tag", fields[15], rs_entry.dest_tag);
        end
        @(posedge clk);
        dec_valid <= 1'b0;
        cdb       <= '0;
    endtask

    // instruction is withdrawn again after one stalled cycle
    task automatic expect_stall();
        @(posedge clk);
        drive_idle();
        dec       <= decode_fields();
        dec_valid <= 1'b1;
        @(negedge clk);
        check_value("dispatch_stall", 1, dispatch_stall);
        check_value("rs_load", 0, rs_load);
        @(posedge clk);
        dec_valid <= 1'b0;
    endtask

    task automatic broadcast();
        cdb_t bus;
        bus.valid = 1'b1;
        bus.tag   = fields[0][2:0];
        bus.value = fields[1];
        @(posedge clk);
        drive_idle();
        cdb <= bus;
    endtask

    task automatic return_credit();
        @(posedge clk);
        drive_idle();
        rs_credit_return <= fields[0][`FU_NUM-1:0];
    endtask

    task automatic expect_commit();
        commit_t got;
        int      n;
        @(posedge clk);
        drive_idle();
        n = 0;
        while (commit_q.size() == 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (commit_q.size() == 0) begin
            $display("timeout: no commit seen within 20 cycles at t=%0t", $time);
            errors++;
        end else begin
            got = commit_q.pop_front();
            check_value("commit_tag", fields[0], got.tag);
            check_value("commit_rd", fields[1], got.rd);
            check_value("commit_has_rd", has_rd_by_tag[fields[0][2:0]], got.has_rd);
            check_value("commit_value", fields[2], got.value);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          want;
        int          case_num;
        int          errors_before;
        logic [7:0]  cmd;
        logic        reading;
        string       line;
        clk              = 1'b0;
        reset            = 1'b1;
        dec              = '0;
        dec_valid        = 1'b0;
        rs_credit_return = '0;
        cdb              = '0;
        errors           = 0;
        pass_count       = 0;
        fail_count       = 0;
        case_num         = 0;
        want             = 0;
        code             = $urandom(32'heabd_906c);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("dispatch_stall", 0, dispatch_stall);
        check_value("rs_load", 0, rs_load);
        check_value("commit_valid", 0, commit.valid);

        fd = $fopen("dispatch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open dispatch_cases.txt");
            errors++;
        end else begin
            reading = 1'b1;
            while (reading) begin
                if ($fscanf(fd, " %c", cmd) != 1) begin
                    reading = 1'b0;
                end else if (cmd == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    errors_before = errors;
                    case_num++;
                    case (cmd)
                        "D": begin
                            want = 16;
                            code = $fscanf(fd, "%d %d %d %d %d %d %d %h %h %d %d %h %d %d %h %d",
                                fields[0], fields[1], fields[2], fields[3], fields[4],
                                fields[5], fields[6], fields[7], fields[8], fields[9],
                                fields[10], fields[11], fields[12], fields[13], fields[14],
                                fields[15]);
                            if (code == want) dispatch_inst();
                        end
                        "S": begin
                            want = 5;
                            code = $fscanf(fd, "%d %d %d %d %d", fields[0], fields[1],
                                           fields[2], fields[3], fields[4]);
                            if (code == want) expect_stall();
                        end
                        "B": begin
                            want = 2;
                            code = $fscanf(fd, "%d %h", fields[0], fields[1]);
                            if (code == want) broadcast();
                        end
                        "R": begin
                            want = 1;
                            code = $fscanf(fd, "%h", fields[0]);
                            if (code == want) return_credit();
                        end
                        "C": begin
                            want = 3;
                            code = $fscanf(fd, "%d %d %h", fields[0], fields[1], fields[2]);
                            if (code == want) expect_commit();
                        end
                        default: begin
                            $display("unknown command %c in cases file", cmd);
                            errors++;
                        end
                    endcase
                    if (errors == errors_before && code != want) begin
                        $display("case %0d has missing fields", case_num);
                        errors++;
                    end
                    if (errors == errors_before) begin
                        pass_count++;
                        $display("case %0d %c ok", case_num, cmd);
                    end else begin
                        fail_count++;
                        $display("case %0d %c failed", case_num, cmd);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        if (commit_q.size() != 0) begin
            $display("%0d commits arrived that no case expected", commit_q.size());
            errors++;
        end
        $display("cases passed %0d failed %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- dispatch_cases.txt
# D fu rd rs1 rs2 has_rd cdb_valid cdb_tag cdb_val load rdy1 tag1 val1 rdy2 tag2 val2 dest
# S fu rd rs1 rs2 has_rd, B tag val, R mask, C tag rd val (val, load and mask in hex)
# independent reads and x0
D 0 1 0 2 1 0 0 0 1 1 0 0 1 0 0 0
# dependents wait on tags 0 and 1
D 1 3 1 0 1 0 0 0 2 0 0 0 1 0 0 1
D 2 4 3 1 1 0 0 0 4 0 1 0 0 0 0 2
# result of tag 1 arrives first
B 1 11110001
D 0 5 3 0 1 0 0 0 1 1 1 11110001 1 0 0 3
R 1
# same-cycle bypass from the bus
D 0 6 1 4 1 1 0 aaaa0000 1 1 0 aaaa0000 0 2 0 4
C 0 1 aaaa0000
C 1 3 11110001
B 2 22220002
C 2 4 22220002
# committed values come from the register file
D 3 7 1 4 1 0 0 0 8 1 0 aaaa0000 1 0 22220002 5
# branch class runs out of credits
D 2 0 5 6 0 0 0 0 4 0 3 0 0 4 0 6
S 2 0 0 0 0
R 4
D 2 0 0 0 0 0 0 0 4 1 0 0 1 0 0 7
# fill the reorder buffer
R 1
D 1 8 7 0 1 0 0 0 2 0 5 0 1 0 0 0
D 3 9 8 2 1 0 0 0 8 0 0 0 1 0 0 1
D 0 10 0 0 1 0 0 0 1 1 0 0 1 0 0 2
R 1
S 0 11 10 5 1
B 3 33330003
C 3 5 33330003
D 0 11 10 5 1 0 0 0 1 0 2 0 1 0 33330003 3
# out-of-order results, in-order commits
B 5 55550005
B 4 44440004
C 4 6 44440004
C 5 7 55550005

//--- compile.f
+incdir+.
dispatch_pkg.sv
arch_regfile.sv
map_table.sv
rob.sv
dispatcher.sv
dispatch_top.sv
tb_dispatch.sv

//--- Bender.yml
package:
  name: dispatch

export_include_dirs:
  - .

sources:
  - dispatch_pkg.sv
  - arch_regfile.sv
  - map_table.sv
  - rob.sv
  - dispatcher.sv
  - dispatch_top.sv
  - target: test
    files:
      - tb_dispatch.sv
